// ==== common/dbg_ahb_pkg.sv ====
// Fixed 32-bit little-endian AHB-Lite bus only; no 64-bit data, no bursts, no locked transfers
package dbg_ahb_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Address and data width of the AHB-Lite port
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Debug word size in bytes
  // Only 1, 2 and 4 carry meaning, anything else is treated as a full word
  typedef logic [3:0] word_size_t;

  //////////////////////////////////////////////////
  // AHB control field types and encodings
  //////////////////////////////////////////////////

  typedef logic [2:0] hsize_t;
  typedef logic [1:0] htrans_t;
  typedef logic [2:0] hburst_t;
  typedef logic [3:0] hprot_t;

  // Transfer size
  localparam hsize_t HSIZE_BYTE  = 3'd0;
  localparam hsize_t HSIZE_HWORD = 3'd1;
  localparam hsize_t HSIZE_WORD  = 3'd2;

  // Transfer type, the unit never issues BUSY or SEQ
  localparam htrans_t HTRANS_IDLE   = 2'd0;
  localparam htrans_t HTRANS_NONSEQ = 2'd2;

  // Single transfers only
  localparam hburst_t HBURST_SINGLE = 3'd0;

  // Data access, privileged, non-bufferable, non-cacheable
  localparam hprot_t HPROT_DEBUG = 4'b0011;

  //////////////////////////////////////////////////
  // Sequencer and request
  //////////////////////////////////////////////////

  // AHB transfer sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE    = 2'd0,
    SEQ_ADDRESS = 2'd1,
    SEQ_DATA    = 2'd2
  } seq_state_t;

  // Decoded debug request, held stable from accept until the data phase ends
  typedef struct packed {
    // Byte address of the access
    addr_t      addr;
    // Write data, sub-word values already copied to every lane
    data_t      wdata;
    // HSIZE derived from the word size
    hsize_t     size;
    // High for a write, low for a read
    logic       write;
    // Original word size, kept for read lane selection
    word_size_t word_size;
  } dbg_req_t;

endpackage

// ==== dbg_biu/dbg_biu_ahb_master.sv ====
// One AHB-Lite single transfer per start pulse; no bursts, no locking, HSEL always high
`timescale 1ns/1ps

module dbg_biu_ahb_master
  import dbg_ahb_pkg::*;
(
  input  logic     HCLK,
  input  logic     ahb_rstn,
  // From request decode
  input  logic     start,
  input  dbg_req_t req,
  // End of data phase, to decode and aligner
  output logic     transfer_ack,
  // AHB-Lite master port
  output logic     HSEL,
  output addr_t    HADDR,
  output data_t    HWDATA,
  output logic     HWRITE,
  output hsize_t   HSIZE,
  output hburst_t  HBURST,
  output hprot_t   HPROT,
  output htrans_t  HTRANS,
  output logic     HMASTLOCK,
  input  logic     HREADY
);

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  seq_state_t state;
  seq_state_t state_next;
  htrans_t    htrans_q;
  htrans_t    htrans_next;

  // Next state and next HTRANS
  always_comb begin
    state_next  = state;
    htrans_next = htrans_q;
    case (state)
      SEQ_IDLE: begin
        if (start) begin
          // Address phase starts on the following cycle
          state_next  = SEQ_ADDRESS;
          htrans_next = HTRANS_NONSEQ;
        end
      end
      SEQ_ADDRESS: begin
        // NONSEQ is shown for exactly one cycle
        state_next  = SEQ_DATA;
        htrans_next = HTRANS_IDLE;
      end
      SEQ_DATA: begin
        // Wait states hold the sequencer here
        if (HREADY) begin
          state_next = SEQ_IDLE;
        end
      end
      default: begin
        state_next  = SEQ_IDLE;
        htrans_next = HTRANS_IDLE;
      end
    endcase
  end

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state    <= SEQ_IDLE;
      htrans_q <= HTRANS_IDLE;
    end else begin
      state    <= state_next;
      htrans_q <= htrans_next;
    end
  end

  // Data phase completes on the cycle HREADY is seen high
  assign transfer_ack = (state == SEQ_DATA) & HREADY;

  //////////////////////////////////////////////////
  // Bus outputs
  //////////////////////////////////////////////////

  assign HTRANS = htrans_q;

  // Address and control straight from the held request
  // Decode keeps req unchanged until biu_rdy rises again
  assign HADDR  = req.addr;
  assign HWRITE = req.write;
  assign HSIZE  = req.size;
  // Write data is valid from the address phase through the data phase
  assign HWDATA = req.wdata;

  // Fixed attributes of every debug access
  assign HSEL      = 1'b1;
  assign HBURST    = HBURST_SINGLE;
  assign HPROT     = HPROT_DEBUG;
  assign HMASTLOCK = 1'b0;

endmodule

// ==== dbg_biu/dbg_biu_read_align.sv ====
// Little-endian lane select only; biu_do and biu_err hold until the next data phase ends
`timescale 1ns/1ps

module dbg_biu_read_align
  import dbg_ahb_pkg::*;
(
  input  logic     HCLK,
  input  logic     ahb_rstn,
  // End of data phase from the sequencer
  input  logic     transfer_ack,
  // Held request, gives lane and size
  input  dbg_req_t req,
  // AHB response
  input  data_t    HRDATA,
  input  logic     HRESP,
  // Debug port results
  output data_t    biu_do,
  output logic     biu_err
);

  //////////////////////////////////////////////////
  // Lane selection
  //////////////////////////////////////////////////

  logic [7:0]  byte_lane;
  logic [15:0] hword_lane;
  data_t       rdata_aligned;

  // Byte lane from address bits 1:0, lane 0 is the low byte
  always_comb begin
    case (req.addr[1:0])
      2'b00:   byte_lane = HRDATA[7:0];
      2'b01:   byte_lane = HRDATA[15:8];
      2'b10:   byte_lane = HRDATA[23:16];
      default: byte_lane = HRDATA[31:24];
    endcase
  end

  // Halfword lane from address bit 1, bit 0 is ignored
  always_comb begin
    if (req.addr[1]) begin
      hword_lane = HRDATA[31:16];
    end else begin
      hword_lane = HRDATA[15:0];
    end
  end

  // Zero extend sub-word results
  always_comb begin
    case (req.word_size)
      4'd1:    rdata_aligned = {24'h0, byte_lane};
      4'd2:    rdata_aligned = {16'h0, hword_lane};
      // Full word and unused size codes pass the bus word through
      default: rdata_aligned = HRDATA;
    endcase
  end

  //////////////////////////////////////////////////
  // Result registers
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      biu_do  <= '0;
      biu_err <= 1'b0;
    end else if (transfer_ack) begin
      // Writes also update biu_do, the debug side ignores it then
      biu_do  <= rdata_aligned;
      // Cleared by the next access that ends with OKAY
      biu_err <= HRESP;
    end
  end

endmodule

// ==== dbg_biu/dbg_biu_request_decode.sv ====
// Accepts one request while biu_rdy is high; strobes during a busy transfer are dropped
`timescale 1ns/1ps

module dbg_biu_request_decode
  import dbg_ahb_pkg::*;
(
  input  logic       HCLK,
  input  logic       ahb_rstn,
  // Debug port
  input  logic       biu_strb,
  input  logic       biu_rw,
  input  addr_t      biu_addr,
  input  data_t      biu_di,
  input  word_size_t biu_word_size,
  output logic       biu_rdy,
  // From the sequencer at the end of the data phase
  input  logic       transfer_ack,
  // To sequencer and aligner
  output logic       start,
  output dbg_req_t   req
);

  //////////////////////////////////////////////////
  // Accept and decode
  //////////////////////////////////////////////////

  logic       accept;
  hsize_t     size_d;
  data_t      wdata_d;

  // Registered request fields
  addr_t      addr_q;
  data_t      wdata_q;
  hsize_t     size_q;
  logic       write_q;
  word_size_t wsize_q;

  // A strobe only counts while the unit is free
  assign accept = biu_strb & biu_rdy;

  // Word size to HSIZE, and lane replication of the write data
  always_comb begin
    case (biu_word_size)
      4'd1: begin
        size_d  = HSIZE_BYTE;
        wdata_d = {4{biu_di[7:0]}};
      end
      4'd2: begin
        size_d  = HSIZE_HWORD;
        wdata_d = {2{biu_di[15:0]}};
      end
      default: begin
        // 4 and all unused codes give a full word
        size_d  = HSIZE_WORD;
        wdata_d = biu_di;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Request registers
  //////////////////////////////////////////////////

  // Control part of the request
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      addr_q  <= '0;
      size_q  <= HSIZE_WORD;
      write_q <= 1'b0;
      wsize_q <= '0;
    end else if (accept) begin
      addr_q  <= biu_addr;
      size_q  <= size_d;
      // biu_rw high means read
      write_q <= ~biu_rw;
      wsize_q <= biu_word_size;
    end
  end

  // Write data payload
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      wdata_q <= '0;
    end else if (accept) begin
      wdata_q <= wdata_d;
    end
  end

  assign req = '{addr: addr_q, wdata: wdata_q, size: size_q, write: write_q,
                 word_size: wsize_q};

  //////////////////////////////////////////////////
  // Start pulse and ready level
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      start   <= 1'b0;
      biu_rdy <= 1'b1;
    end else begin
      // One cycle pulse after the accept edge
      start <= accept;
      if (accept) begin
        biu_rdy <= 1'b0;
      end else if (transfer_ack) begin
        // Free again once the data phase has ended
        biu_rdy <= 1'b1;
      end
    end
  end

endmodule

// ==== dbg_biu/dbg_biu_top.sv ====
// Single HCLK domain; one outstanding debug request, 32-bit little-endian AHB-Lite single transfers
`timescale 1ns/1ps

module dbg_biu_top
  import dbg_ahb_pkg::*;
(
  input  logic       HCLK,
  input  logic       ahb_rstn,
  // Debug port
  input  logic       biu_strb,
  input  logic       biu_rw,
  input  addr_t      biu_addr,
  input  data_t      biu_di,
  input  word_size_t biu_word_size,
  output data_t      biu_do,
  output logic       biu_rdy,
  output logic       biu_err,
  // AHB-Lite master port
  output logic       HSEL,
  output addr_t      HADDR,
  output data_t      HWDATA,
  input  data_t      HRDATA,
  output logic       HWRITE,
  output hsize_t     HSIZE,
  output hburst_t    HBURST,
  output hprot_t     HPROT,
  output htrans_t    HTRANS,
  output logic       HMASTLOCK,
  input  logic       HREADY,
  input  logic       HRESP
);

  //////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////

  dbg_req_t req;
  logic     start;
  logic     transfer_ack;

  // Request decode and ready level
  dbg_biu_request_decode dbg_biu_request_decode_inst (
    .HCLK          (HCLK),
    .ahb_rstn      (ahb_rstn),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_addr      (biu_addr),
    .biu_di        (biu_di),
    .biu_word_size (biu_word_size),
    .biu_rdy       (biu_rdy),
    .transfer_ack  (transfer_ack),
    .start         (start),
    .req           (req)
  );

  // Transfer sequencer
  dbg_biu_ahb_master dbg_biu_ahb_master_inst (
    .HCLK         (HCLK),
    .ahb_rstn     (ahb_rstn),
    .start        (start),
    .req          (req),
    .transfer_ack (transfer_ack),
    .HSEL         (HSEL),
    .HADDR        (HADDR),
    .HWDATA       (HWDATA),
    .HWRITE       (HWRITE),
    .HSIZE        (HSIZE),
    .HBURST       (HBURST),
    .HPROT        (HPROT),
    .HTRANS       (HTRANS),
    .HMASTLOCK    (HMASTLOCK),
    .HREADY       (HREADY)
  );

  // Read data and error capture
  dbg_biu_read_align dbg_biu_read_align_inst (
    .HCLK         (HCLK),
    .ahb_rstn     (ahb_rstn),
    .transfer_ack (transfer_ack),
    .req          (req),
    .HRDATA       (HRDATA),
    .HRESP        (HRESP),
    .biu_do       (biu_do),
    .biu_err      (biu_err)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module dbg_biu_tb \
  -o dbg_biu_sim > sim.log 2>&1 &&
  ./obj_dir/dbg_biu_sim >> sim.log 2>&1

cat sim.log

grep -q '^Result: PASSED$' sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// ==== sim.f ====
common/dbg_ahb_pkg.sv
dbg_biu/dbg_biu_request_decode.sv
dbg_biu/dbg_biu_ahb_master.sv
dbg_biu/dbg_biu_read_align.sv
dbg_biu/dbg_biu_top.sv
sim/dbg_biu_assertions.sv
sim/dbg_biu_tb.sv

// ==== sim/dbg_biu_assertions.sv ====
// Bound into dbg_biu_ahb_master; checks only single transfers with one request outstanding
`timescale 1ns/1ps

module dbg_biu_assertions
  import dbg_ahb_pkg::*;
(
  input logic       HCLK,
  input logic       ahb_rstn,
  input htrans_t    HTRANS,
  input addr_t      HADDR,
  input seq_state_t state,
  input logic       transfer_ack
);

  // Set by NONSEQ, cleared when the data phase ends
  logic pending;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      pending <= 1'b0;
    end else if (HTRANS == HTRANS_NONSEQ) begin
      pending <= 1'b1;
    end else if (transfer_ack) begin
      pending <= 1'b0;
    end
  end

  // NONSEQ lasts one cycle
  nonseq_one_cycle: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    HTRANS == HTRANS_NONSEQ |=> HTRANS == HTRANS_IDLE)
    else $error("NONSEQ held longer than one cycle");

  haddr_stable: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    state != SEQ_IDLE |=> $stable(HADDR))
    else $error("HADDR changed during a transfer");

  // One transfer at a time
  no_overlap: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    HTRANS == HTRANS_NONSEQ |-> !pending)
    else $error("second NONSEQ before the data phase ended");

endmodule

bind dbg_biu_ahb_master dbg_biu_assertions dbg_biu_assertions_inst (
  .HCLK         (HCLK),
  .ahb_rstn     (ahb_rstn),
  .HTRANS       (HTRANS),
  .HADDR        (HADDR),
  .state        (state),
  .transfer_ack (transfer_ack)
);

// ==== sim/dbg_biu_tb.sv ====
// Self-checking testbench; 64-word slave at HADDR[7:2], error region HADDR[31:28] == 4'hF
`timescale 1ns/1ps

module dbg_biu_tb
  import dbg_ahb_pkg::*;
();

  //////////////////////////////////////////////////
  // Signals and scoreboard state
  //////////////////////////////////////////////////

  // Number of requests in the test sequence
  localparam int NUM_REQ = 45;

  logic HCLK;
  logic ahb_rstn;
  logic biu_strb;
  logic biu_rw;
  addr_t biu_addr;
  data_t biu_di;
  word_size_t biu_word_size;
  data_t biu_do;
  logic biu_rdy;
  logic biu_err;
  logic HSEL;
  addr_t HADDR;
  data_t HWDATA;
  data_t HRDATA;
  logic HWRITE;
  hsize_t HSIZE;
  hburst_t HBURST;
  hprot_t HPROT;
  htrans_t HTRANS;
  logic HMASTLOCK;
  logic HREADY;
  logic HRESP;

  data_t mem [64];
  data_t shadow [64];
  logic [31:0] rng_state;
  int cyc;
  int cyc_accept;
  int issued;
  int checks_done;
  int nonseq_count;
  int next_waits;

  // Expected results of the request in flight
  logic exp_wr;
  logic exp_err;
  logic exp_check_do;
  data_t exp_do;
  data_t exp_wdata;
  addr_t exp_addr;
  hsize_t exp_size;
  int exp_latency;
  int exp_idx;

  // Address phase values seen by the slave
  hsize_t cap_size;
  data_t cap_wdata;
  addr_t cap_addr;
  logic cap_write;

  // Slave data phase tracking
  logic s_active;
  logic s_write;
  logic s_err;
  logic s_err_first;
  addr_t s_addr;
  hsize_t s_size;
  int s_waits;

  dbg_biu_top dbg_biu_top_inst (.*);

  //////////////////////////////////////////////////
  // Clock, cycle count, reporting
  //////////////////////////////////////////////////

  always #50 HCLK = ~HCLK;

  always @(posedge HCLK) begin
    cyc <= cyc + 1;
  end

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Expected word after a write of the given debug size
  function automatic data_t merge_write(data_t old, addr_t addr, data_t data, word_size_t ws);
    data_t res;
    int lane;
    res = old;
    lane = int'(addr[1:0]);
    case (ws)
      4'd1: res[lane*8 +: 8] = data[7:0];
      4'd2: res[(lane/2)*16 +: 16] = data[15:0];
      default: res = data;
    endcase
    return res;
  endfunction

  // Expected zero-extended read of one lane
  function automatic data_t align_read(data_t word, addr_t addr, word_size_t ws);
    int lane;
    lane = int'(addr[1:0]);
    case (ws)
      4'd1: return {24'h0, word[lane*8 +: 8]};
      4'd2: return {16'h0, word[(lane/2)*16 +: 16]};
      default: return word;
    endcase
  endfunction

  function automatic data_t lane_pattern(data_t data, word_size_t ws);
    case (ws)
      4'd1: return {data[7:0], data[7:0], data[7:0], data[7:0]};
      4'd2: return {data[15:0], data[15:0]};
      default: return data;
    endcase
  endfunction

  function automatic hsize_t size_of(word_size_t ws);
    case (ws)
      4'd1: return HSIZE_BYTE;
      4'd2: return HSIZE_HWORD;
      default: return HSIZE_WORD;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Memory slave with wait states
  //////////////////////////////////////////////////

  always @(negedge HCLK) begin
    data_t mask;
    if (s_active) begin
      if (s_err && s_err_first) begin
        // First cycle of the two-cycle error response
        HREADY <= 1'b0;
        HRESP <= 1'b1;
        s_err_first <= 1'b0;
      end else if (!s_err && s_waits > 0) begin
        HREADY <= 1'b0;
        s_waits <= s_waits - 1;
      end else begin
        HREADY <= 1'b1;
        HRESP <= s_err;
        s_active <= 1'b0;
        HRDATA <= s_err ? 32'h0 : mem[s_addr[7:2]];
        if (s_write && !s_err) begin
          case (s_size)
            HSIZE_BYTE: mask = 32'hFF << (8 * int'(s_addr[1:0]));
            HSIZE_HWORD: mask = s_addr[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default: mask = '1;
          endcase
          mem[s_addr[7:2]] <= (mem[s_addr[7:2]] & ~mask) | (HWDATA & mask);
        end
      end
    end else begin
      HREADY <= 1'b1;
      HRESP <= 1'b0;
    end
    // Address phase seen here, the data phase follows on the next cycle
    if (HTRANS == HTRANS_NONSEQ) begin
      nonseq_count <= nonseq_count + 1;
      s_active <= 1'b1;
      s_addr <= HADDR;
      s_write <= HWRITE;
      s_size <= HSIZE;
      s_waits <= next_waits;
      s_err <= (HADDR[31:28] == 4'hF);
      s_err_first <= 1'b1;
      cap_size <= HSIZE;
      cap_wdata <= HWDATA;
      cap_addr <= HADDR;
      cap_write <= HWRITE;
    end
  end

  //////////////////////////////////////////////////
  // Request driver
  //////////////////////////////////////////////////

  task automatic access(input logic wr, input addr_t addr, input data_t data,
                        input word_size_t ws, input int waits, input logic busy_strb);
    int target;
    @(negedge HCLK);
    next_waits = waits;
    exp_wr = wr;
    exp_addr = addr;
    exp_err = (addr[31:28] == 4'hF);
    exp_idx = int'(addr[7:2]);
    // Error response always costs one extra cycle
    exp_latency = exp_err ? 4 : 3 + waits;
    exp_check_do = !wr && !exp_err;
    exp_do = align_read(shadow[exp_idx], addr, ws);
    exp_wdata = lane_pattern(data, ws);
    exp_size = size_of(ws);
    if (wr && !exp_err) begin
      shadow[exp_idx] = merge_write(shadow[exp_idx], addr, data, ws);
    end
    biu_strb = 1'b1;
    biu_rw = ~wr;
    biu_addr = addr;
    biu_di = data;
    biu_word_size = ws;
    issued = issued + 1;
    target = issued;
    @(negedge HCLK);
    cyc_accept = cyc;
    if (busy_strb) begin
      // Strobe held while busy must be ignored
      biu_addr = addr ^ 32'h4;
      @(negedge HCLK);
    end
    biu_strb = 1'b0;
    wait (checks_done == target);
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////

  initial begin
    wait (ahb_rstn === 1'b1);
    forever begin
      @(posedge biu_rdy);
      @(negedge HCLK);
      assert (cyc - cyc_accept == exp_latency) else
        report_mismatch($sformatf("latency %0d, expected %0d", cyc - cyc_accept, exp_latency));
      assert (biu_err == exp_err) else
        report_mismatch($sformatf("biu_err %0b, expected %0b", biu_err, exp_err));
      if (exp_check_do) begin
        assert (biu_do == exp_do) else
          report_mismatch($sformatf("biu_do %h, expected %h", biu_do, exp_do));
      end
      assert (nonseq_count == issued) else
        report_mismatch($sformatf("%0d transfers for %0d requests", nonseq_count, issued));
      assert (cap_addr == exp_addr && cap_write == exp_wr) else
        report_mismatch($sformatf("HADDR %h HWRITE %0b, expected %h %0b",
                                  cap_addr, cap_write, exp_addr, exp_wr));
      assert (cap_size == exp_size) else
        report_mismatch($sformatf("HSIZE %0d, expected %0d", cap_size, exp_size));
      if (exp_wr) begin
        assert (cap_wdata == exp_wdata) else
          report_mismatch($sformatf("HWDATA %h, expected %h", cap_wdata, exp_wdata));
        assert (mem[exp_idx] == shadow[exp_idx]) else
          report_mismatch($sformatf("mem %h, expected %h", mem[exp_idx], shadow[exp_idx]));
      end
      checks_done = checks_done + 1;
    end
  end

  // Watchdog sized from the request count plus reset
  initial begin
    #((NUM_REQ * 12 + 20) * 100);
    $display("Timeout: the DUT did not finish all requests in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    word_size_t ws;
    addr_t addr;
    HCLK = 1'b0;
    ahb_rstn = 1'b0;
    biu_strb = 1'b0;
    biu_rw = 1'b1;
    biu_addr = '0;
    biu_di = '0;
    biu_word_size = 4'd4;
    HRDATA = '0;
    HREADY = 1'b1;
    HRESP = 1'b0;
    rng_state = 32'd71905;
    cyc = 0;
    issued = 0;
    checks_done = 0;
    nonseq_count = 0;
    next_waits = 0;
    s_active = 1'b0;
    // Fill depends on the whole word index
    for (int i = 0; i < 64; i++) begin
      mem[i] = {8'(i), 8'(~i), 8'(i * 7), 8'(i ^ 8'h5A)};
      shadow[i] = mem[i];
    end
    repeat (10) @(negedge HCLK);
    ahb_rstn = 1'b1;

    // After reset
    @(negedge HCLK);
    assert (biu_rdy && !biu_err && HTRANS == HTRANS_IDLE && biu_do == '0) else
      report_mismatch("idle outputs wrong after reset");
    assert (HBURST == 3'd0 && HPROT == 4'b0011 && !HMASTLOCK && HSEL) else
      report_mismatch("fixed AHB attributes wrong");

    // Word write and read-back
    access(1'b1, 32'h10, 32'hCAFE_F00D, 4'd4, 0, 1'b0);
    access(1'b0, 32'h10, 32'h0, 4'd4, 0, 1'b0);

    // Byte and halfword writes with random waits
    for (int n = 0; n < 16; n++) begin
      rnd = lcg_next();
      ws = rnd[31] ? 4'd2 : 4'd1;
      addr = {24'h0, rnd[7:0]};
      if (ws == 4'd2) addr[0] = 1'b0;
      access(1'b1, addr, lcg_next(), ws, int'(rnd[17:16]), rnd[20]);
    end

    // Reads of all sizes with random waits
    for (int n = 0; n < 24; n++) begin
      rnd = lcg_next();
      case (rnd[9:8])
        2'd0: ws = 4'd1;
        2'd1: ws = 4'd2;
        default: ws = 4'd4;
      endcase
      addr = {24'h0, rnd[7:0]};
      if (ws != 4'd1) addr[0] = 1'b0;
      if (ws == 4'd4) addr[1] = 1'b0;
      access(1'b0, addr, 32'h0, ws, int'(rnd[17:16]), rnd[21]);
    end

    // Error region, then a normal access clears the flag
    access(1'b1, 32'hF000_0020, 32'h1234_5678, 4'd4, 0, 1'b0);
    access(1'b0, 32'hF000_0024, 32'h0, 4'd2, 0, 1'b0);
    access(1'b0, 32'h20, 32'h0, 4'd4, 0, 1'b0);

    $display("Result: PASSED");
    $finish;
  end

endmodule
